/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // cache geometry
    localparam int CACHE_LINES = 16;
    localparam int LINE_WORDS  = 4;                  // 16-byte line
    localparam int INDEX_W     = 4;
    localparam int WORD_W      = 2;
    localparam int TAG_W       = 32 - INDEX_W - WORD_W - 2;

    // address map
    localparam logic [3:0] SDRAM_REGION = 4'hA;      // only cacheable window

    // AXI read encodings
    localparam logic [7:0] BURST_LEN       = 8'd3;   // 4 beats per line
    localparam logic [2:0] AXI_SIZE_WORD   = 3'b010;
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [3:0] FETCH_ARID      = 4'b1000;

    // refill master states
    localparam logic [1:0] READ_IDLE = 2'd0;
    localparam logic [1:0] READ_ADDR = 2'd1;
    localparam logic [1:0] READ_DATA = 2'd2;

    // decoder flow control
    localparam int FETCH_CREDITS = 2;                // granted after reset
    localparam int CREDIT_W      = $clog2(FETCH_CREDITS + 1);

    // one fetch address, seen by the cache as tag/index/word
    // and by the bus as region/word address
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [WORD_W-1:0]  word;
            logic [1:0]         byte_off;
        } line;
        struct packed {
            logic [3:0]  region;
            logic [25:0] word_addr;
            logic [1:0]  byte_off;
        } bus;
    } fetch_addr_u;

endpackage

`default_nettype wire

/* icache_array.sv */
`default_nettype none

module icache_array import fetch_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              flush_i,
    // lookup
    input  wire              req_fire_i,
    input  wire fetch_addr_u req_addr_i,
    output logic             hit_valid_o,
    output logic [31:0]      hit_data_o,
    output logic             miss_valid_o,
    output fetch_addr_u      miss_addr_o,
    output logic             miss_cacheable_o,
    // refill beats
    input  wire              beat_valid_i,
    input  wire  [1:0]       beat_idx_i,
    input  wire  [31:0]      beat_data_i,
    input  wire              beat_last_i,
    input  wire              beat_drop_i
);

    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    logic [31:0]            data_q [CACHE_LINES][LINE_WORDS];

    logic                   miss_pending;       // miss issued, last beat not yet seen
    logic                   lookup_cacheable;
    logic                   lookup_hit;
    logic                   fill_en;
    logic [INDEX_W-1:0]     fill_index;

    assign lookup_cacheable = (req_addr_i.bus.region == SDRAM_REGION);

    // bypass addresses never hit, even if a tag happened to match
    assign lookup_hit = lookup_cacheable
                        && valid_q[req_addr_i.line.index]
                        && (tag_q[req_addr_i.line.index] == req_addr_i.line.tag);

    assign fill_index = miss_addr_o.line.index;
    assign fill_en    = beat_valid_i && miss_pending && miss_cacheable_o && !beat_drop_i;

    // registered lookup result
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_valid_o  <= 1'b0;
            miss_valid_o <= 1'b0;
            miss_pending <= 1'b0;
        end else begin
            hit_valid_o  <= req_fire_i && lookup_hit;
            miss_valid_o <= req_fire_i && !lookup_hit;   // one-cycle pulse to the master
            if (req_fire_i && !lookup_hit) begin
                miss_pending <= 1'b1;
            end else if (beat_valid_i && beat_last_i) begin
                miss_pending <= 1'b0;                    // dropped bursts end here too
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire_i) begin
            hit_data_o       <= data_q[req_addr_i.line.index][req_addr_i.line.word];
            miss_addr_o      <= req_addr_i;
            miss_cacheable_o <= lookup_cacheable;
        end
    end

    // line fill, word by word as the beats come in
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[fill_index][beat_idx_i] <= beat_data_i;
            if (beat_last_i) begin
                tag_q[fill_index] <= miss_addr_o.line.tag;
            end
        end
    end

    // line becomes valid only after the whole burst landed
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                               // invalidate everything
        end else if (fill_en && beat_last_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // the refill master only answers misses this array raised
    a_beat_has_miss: assert property (@(posedge clk) disable iff (reset)
        beat_valid_i |-> miss_pending);

endmodule

`default_nettype wire

/* axi_refill_master.sv */
`default_nettype none

module axi_refill_master import fetch_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              flush_i,
    // miss request from the cache
    input  wire              miss_valid_i,
    input  wire fetch_addr_u miss_addr_i,
    input  wire              miss_cacheable_i,
    // AXI read address
    output logic             arvalid_o,
    input  wire              arready_i,
    output logic [31:0]      araddr_o,
    output logic [3:0]       arid_o,
    output logic [7:0]       arlen_o,
    output logic [2:0]       arsize_o,
    output logic [1:0]       arburst_o,
    // AXI read data
    input  wire              rvalid_i,
    output logic             rready_o,
    input  wire  [31:0]      rdata_i,
    input  wire  [1:0]       rresp_i,
    input  wire              rlast_i,
    input  wire  [3:0]       rid_i,
    // beats to the cache and the merge
    output logic             beat_valid_o,
    output logic [1:0]       beat_idx_o,
    output logic [31:0]      beat_data_o,
    output logic             beat_last_o,
    output logic             beat_drop_o
);

    logic [1:0]        state_q;
    logic [31:0]       araddr_q;
    logic [7:0]        arlen_q;
    logic [1:0]        arburst_q;
    logic [WORD_W-1:0] beat_cnt;
    logic              flushed_q;       // flush seen during this transaction
    logic              ar_fire;
    logic              r_fire;
    logic              start;

    assign start   = (state_q == READ_IDLE) && miss_valid_i;
    assign ar_fire = arvalid_o && arready_i;
    assign r_fire  = rvalid_i && rready_o;

    // AR channel
    assign arvalid_o = (state_q == READ_ADDR);
    assign araddr_o  = araddr_q;
    assign arid_o    = FETCH_ARID;
    assign arlen_o   = arlen_q;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = arburst_q;

    // R channel, always ready while a burst is open
    assign rready_o = (state_q == READ_DATA);

    assign beat_valid_o = r_fire;
    assign beat_idx_o   = beat_cnt;
    assign beat_data_o  = rdata_i;
    assign beat_last_o  = r_fire && rlast_i;
    assign beat_drop_o  = flushed_q || flush_i;  // a beat on the flush cycle is dropped too

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= READ_IDLE;
            flushed_q <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            case (state_q)
                READ_IDLE: begin
                    if (miss_valid_i) begin
                        state_q   <= READ_ADDR;
                        flushed_q <= flush_i;
                        beat_cnt  <= '0;
                    end
                end
                READ_ADDR: begin
                    if (flush_i) begin
                        flushed_q <= 1'b1;
                    end
                    if (ar_fire) begin
                        state_q <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (flush_i) begin
                        flushed_q <= 1'b1;
                    end
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + WORD_W'(1);
                        if (rlast_i) begin
                            state_q <= READ_IDLE;   // burst always runs to rlast
                        end
                    end
                end
                default: begin
                    state_q <= READ_IDLE;
                end
            endcase
        end
    end

    // request attributes, captured once per miss
    always_ff @(posedge clk) begin
        if (start) begin
            if (miss_cacheable_i) begin
                // whole line from word 0
                araddr_q  <= {miss_addr_i.line.tag, miss_addr_i.line.index,
                              {(WORD_W + 2){1'b0}}};
                arlen_q   <= BURST_LEN;
                arburst_q <= AXI_BURST_INCR;
            end else begin
                araddr_q  <= {miss_addr_i.bus.region, miss_addr_i.bus.word_addr, 2'b00};
                arlen_q   <= 8'd0;                  // single word
                arburst_q <= AXI_BURST_FIXED;
            end
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o));

    // slave ends the burst on the beat the length asked for, with our id
    a_r_last: assert property (@(posedge clk) disable iff (reset)
        r_fire |-> (rid_i == FETCH_ARID) && !$isunknown(rresp_i)
                   && (rlast_i == (beat_cnt == arlen_q[WORD_W-1:0])));

endmodule

`default_nettype wire

/* fetch_return_merge.sv */
`default_nettype none

module fetch_return_merge import fetch_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                flush_i,
    // hit path
    input  wire                hit_valid_i,
    input  wire  [31:0]        hit_data_i,
    // refill path
    input  wire  [WORD_W-1:0]  miss_word_i,
    input  wire                beat_valid_i,
    input  wire  [1:0]         beat_idx_i,
    input  wire  [31:0]        beat_data_i,
    input  wire                beat_last_i,
    input  wire                beat_drop_i,
    // decoder side
    input  wire                credit_i,
    output logic               resp_valid_o,
    output logic [31:0]        resp_data_o,
    output logic               fetch_done_o
);

    logic                held_valid;
    logic [31:0]         held_data;
    logic                burst_open;     // beats of the current burst still to come
    logic                active;         // fetch seen here, not yet done
    logic [CREDIT_W-1:0] credit_cnt;

    logic                resp_fire;
    logic                beat_match;
    logic                held_next;
    logic                burst_next;
    logic                active_now;

    assign resp_fire    = held_valid && (credit_cnt != '0) && !flush_i;
    assign resp_valid_o = resp_fire;
    assign resp_data_o  = held_data;

    // bypass beats come with index 0 and miss_word_i is 0 then
    assign beat_match = beat_valid_i && !beat_drop_i && (beat_idx_i == miss_word_i);

    always_comb begin
        held_next = held_valid;
        if (resp_fire) begin
            held_next = 1'b0;
        end
        if (hit_valid_i || beat_match) begin
            held_next = 1'b1;
        end
        if (flush_i) begin
            held_next = 1'b0;                   // held word is stale now
        end
        burst_next = burst_open;
        if (beat_valid_i) begin
            burst_next = !beat_last_i;
        end
    end

    assign active_now   = active || hit_valid_i || beat_valid_i;
    assign fetch_done_o = active_now && !held_next && !burst_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
            burst_open <= 1'b0;
            active     <= 1'b0;
            credit_cnt <= CREDIT_W'(FETCH_CREDITS);
        end else begin
            held_valid <= held_next;
            burst_open <= burst_next;
            active     <= active_now && !fetch_done_o;
            case ({credit_i, resp_fire})
                2'b10:   credit_cnt <= credit_cnt + CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt - CREDIT_W'(1);
                default: credit_cnt <= credit_cnt;  // none, or one in one out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid_i) begin
            held_data <= hit_data_i;
        end else if (beat_match) begin
            held_data <= beat_data_i;
        end
    end

    // decoder only returns credits it was charged for
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_i && !resp_fire |-> credit_cnt < CREDIT_W'(FETCH_CREDITS));

endmodule

`default_nettype wire

/* ifetch_top.sv */
`default_nettype none

module ifetch_top import fetch_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         flush_i,
    // fetch request
    input  wire         req_valid_i,
    input  wire  [31:0] req_addr_i,
    output logic        req_ready_o,
    // response to decoder
    input  wire         credit_i,
    output logic        resp_valid_o,
    output logic [31:0] resp_data_o,
    // AXI read master
    output logic        arvalid_o,
    input  wire         arready_i,
    output logic [31:0] araddr_o,
    output logic [3:0]  arid_o,
    output logic [7:0]  arlen_o,
    output logic [2:0]  arsize_o,
    output logic [1:0]  arburst_o,
    input  wire         rvalid_i,
    output logic        rready_o,
    input  wire  [31:0] rdata_i,
    input  wire  [1:0]  rresp_i,
    input  wire         rlast_i,
    input  wire  [3:0]  rid_i
);

    logic              busy;
    logic              req_fire;
    logic              fetch_done;

    logic              hit_valid;
    logic [31:0]       hit_data;
    logic              miss_valid;
    fetch_addr_u       miss_addr;
    logic              miss_cacheable;
    logic [WORD_W-1:0] miss_word;

    logic              beat_valid;
    logic [1:0]        beat_idx;
    logic [31:0]       beat_data;
    logic              beat_last;
    logic              beat_drop;

    // one fetch at a time; a request in the flush cycle waits a cycle
    assign req_ready_o = !busy && !flush_i;
    assign req_fire    = req_valid_i && req_ready_o;

    // a bypass read returns just the word, at beat 0
    assign miss_word = miss_cacheable ? miss_addr.line.word : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (req_fire) begin
            busy <= 1'b1;
        end else if (fetch_done) begin
            busy <= 1'b0;
        end
    end

    icache_array u_icache (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .req_fire_i       (req_fire),
        .req_addr_i       (req_addr_i),
        .hit_valid_o      (hit_valid),
        .hit_data_o       (hit_data),
        .miss_valid_o     (miss_valid),
        .miss_addr_o      (miss_addr),
        .miss_cacheable_o (miss_cacheable),
        .beat_valid_i     (beat_valid),
        .beat_idx_i       (beat_idx),
        .beat_data_i      (beat_data),
        .beat_last_i      (beat_last),
        .beat_drop_i      (beat_drop)
    );

    axi_refill_master u_refill (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .miss_valid_i     (miss_valid),
        .miss_addr_i      (miss_addr),
        .miss_cacheable_i (miss_cacheable),
        .arvalid_o        (arvalid_o),
        .arready_i        (arready_i),
        .araddr_o         (araddr_o),
        .arid_o           (arid_o),
        .arlen_o          (arlen_o),
        .arsize_o         (arsize_o),
        .arburst_o        (arburst_o),
        .rvalid_i         (rvalid_i),
        .rready_o         (rready_o),
        .rdata_i          (rdata_i),
        .rresp_i          (rresp_i),
        .rlast_i          (rlast_i),
        .rid_i            (rid_i),
        .beat_valid_o     (beat_valid),
        .beat_idx_o       (beat_idx),
        .beat_data_o      (beat_data),
        .beat_last_o      (beat_last),
        .beat_drop_o      (beat_drop)
    );

    fetch_return_merge u_merge (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .hit_valid_i  (hit_valid),
        .hit_data_i   (hit_data),
        .miss_word_i  (miss_word),
        .beat_valid_i (beat_valid),
        .beat_idx_i   (beat_idx),
        .beat_data_i  (beat_data),
        .beat_last_i  (beat_last),
        .beat_drop_i  (beat_drop),
        .credit_i     (credit_i),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .fetch_done_o (fetch_done)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`default_nettype none

module tb_axi_mem import fetch_pkg::*; #(
    parameter int SEED = 15132
) (
    input  wire         clk,
    input  wire         reset,
    // AXI read slave
    input  wire         arvalid_i,
    output logic        arready_o,
    input  wire  [31:0] araddr_i,
    input  wire  [3:0]  arid_i,
    input  wire  [7:0]  arlen_i,
    input  wire  [1:0]  arburst_i,
    output logic        rvalid_o,
    input  wire         rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rlast_o,
    output logic [3:0]  rid_o,
    // lookup port for the reference model
    input  wire  [31:0] model_addr_i,
    output logic [31:0] model_data_o,
    output int          ar_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    integer      seed;
    logic        ar_fire;
    logic        r_fire;
    logic        in_reset;
    logic        in_burst;          // AR taken, rlast not yet accepted
    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [7:0]  beat_q;
    logic [1:0]  burst_q;
    logic [3:0]  id_q;

    // pattern over the whole word address, byte lane ignored
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b10} ^ {addr[15:2], addr[31:14]} ^ 32'h6d3a_91c4;
    endfunction

    assign model_data_o = mem_word(model_addr_i);

    initial begin
        seed       = SEED;
        arready_o  = 1'b0;
        rvalid_o   = 1'b0;
        rdata_o    = '0;
        rresp_o    = 2'b00;           // always OKAY
        rlast_o    = 1'b0;
        rid_o      = '0;
        ar_count_o = 0;
        in_burst   = 1'b0;
        addr_q     = '0;
        len_q      = '0;
        beat_q     = '0;
        burst_q    = '0;
        id_q       = '0;
        forever begin
            // handshakes are settled by mid cycle
            @(negedge clk);
            in_reset = reset;
            ar_fire  = arvalid_i && arready_o;
            r_fire   = rvalid_o && rready_i;
            if (ar_fire) begin
                addr_q   = araddr_i;
                len_q    = arlen_i;
                burst_q  = arburst_i;
                id_q     = arid_i;
                beat_q   = '0;
                in_burst = 1'b1;
                ar_count_o++;
            end
            @(posedge clk);
            #2;
            if (in_reset) begin
                in_burst  = 1'b0;
                arready_o = 1'b0;
                rvalid_o  = 1'b0;
                rlast_o   = 1'b0;
            end else begin
                if (r_fire) begin
                    beat_q++;
                    if (rlast_o) begin
                        in_burst = 1'b0;
                    end
                end
                // a beat on offer stays until taken
                if (in_burst && (r_fire || !rvalid_o)) begin
                    rvalid_o = ($random(seed) & 3) != 0;
                    rdata_o  = mem_word(burst_q == AXI_BURST_INCR ?
                                        addr_q + {22'd0, beat_q, 2'b00} : addr_q);
                    rlast_o  = (beat_q == len_q);
                    rid_o    = id_q;
                end else if (!in_burst) begin
                    rvalid_o = 1'b0;
                    rlast_o  = 1'b0;
                end
                arready_o = !in_burst && (($random(seed) & 1) != 0);
            end
        end
    end

endmodule

`default_nettype wire

/* tb_ifetch_top.sv */
`default_nettype none

module tb_ifetch_top import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQS = 300;
    localparam int TIMEOUT  = NUM_REQS * 40;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_ready;
    logic        credit;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [3:0]  rid;
    logic [31:0] model_addr;
    logic [31:0] model_data;
    int          ar_count;

    // reference model
    integer                 seed;
    int                     cycles       = 0;
    int                     mismatches   = 0;
    int                     failures     = 0;
    int                     credits      = FETCH_CREDITS;  // mirror of the DUT counter
    logic [CACHE_LINES-1:0] line_valid   = '0;
    logic [TAG_W-1:0]       line_tag [CACHE_LINES];
    fetch_addr_u            acc_addr;                      // last accepted request
    logic [31:0]            exp_data;
    logic                   req_cacheable = 1'b0;
    logic                   req_hit       = 1'b0;
    logic                   req_flushed   = 1'b0;
    logic                   resp_owed     = 1'b0;
    logic                   ar_owed       = 1'b0;
    logic                   burst_open    = 1'b0;
    int                     accept_cycle  = 0;
    int                     accepted      = 0;
    int                     responses     = 0;
    int                     dropped       = 0;
    int                     ar_expected   = 0;
    int                     sent          = 0;
    logic                   run_done      = 1'b0;

    ifetch_top DUT (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_ready_o  (req_ready),
        .credit_i     (credit),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .arvalid_o    (arvalid),
        .arready_i    (arready),
        .araddr_o     (araddr),
        .arid_o       (arid),
        .arlen_o      (arlen),
        .arsize_o     (arsize),
        .arburst_o    (arburst),
        .rvalid_i     (rvalid),
        .rready_o     (rready),
        .rdata_i      (rdata),
        .rresp_i      (rresp),
        .rlast_i      (rlast),
        .rid_i        (rid)
    );

    tb_axi_mem #(.SEED(15132)) u_mem (
        .clk          (clk),
        .reset        (reset),
        .arvalid_i    (arvalid),
        .arready_o    (arready),
        .araddr_i     (araddr),
        .arid_i       (arid),
        .arlen_i      (arlen),
        .arburst_i    (arburst),
        .rvalid_o     (rvalid),
        .rready_i     (rready),
        .rdata_o      (rdata),
        .rresp_o      (rresp),
        .rlast_o      (rlast),
        .rid_o        (rid),
        .model_addr_i (model_addr),
        .model_data_o (model_data),
        .ar_count_o   (ar_count)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        failures++;
    endtask

    task automatic finish_run(input logic timed_out);
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // two regions, two tags per index, four lines
    function automatic logic [31:0] pick_address();
        logic [3:0] region;
        logic       tag_bit;
        logic [3:0] index;
        logic [1:0] word;
        region  = (($random(seed) & 1) != 0) ? SDRAM_REGION : 4'h8;
        tag_bit = 1'($random(seed));
        index   = 4'($random(seed) & 3);
        word    = 2'($random(seed));
        return {region, 19'h0, tag_bit, index, word, 2'b00};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // monitor and model, sampled mid cycle
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (run_done) begin
            check_value("responses", accepted - dropped, responses);
            check_value("AR count", ar_expected, ar_count);
            finish_run(1'b0);
        end else if (cycles >= TIMEOUT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            finish_run(1'b1);
        end else if (!reset) begin
            if (flush) begin
                line_valid  = '0;
                req_flushed = 1'b1;
                if (resp_owed) begin
                    dropped++;
                end
                resp_owed = 1'b0;
            end
            if (resp_valid) begin
                if (!resp_owed) begin
                    report_error("response seen with no request owed");
                end
                if (credits == 0) begin
                    report_error("response sent with no credit left");
                end
                if (cycles < accept_cycle + 2) begin
                    report_error("response sooner than 2 cycles after acceptance");
                end
                check_value("resp_data", exp_data, resp_data);
                resp_owed = 1'b0;
                responses++;
                credits--;
            end else if (resp_owed && req_hit && credits > 0
                         && cycles == accept_cycle + 2) begin
                report_error("hit with credit did not respond 2 cycles after acceptance");
            end
            if (credit) begin
                credits++;
            end
            if (arvalid && arready) begin
                if (!ar_owed) begin
                    report_error("AR issued for a request that should hit");
                end
                check_value("arlen", req_cacheable ? 32'd3 : 32'd0, 32'(arlen));
                check_value("arburst", req_cacheable ? 32'(AXI_BURST_INCR) :
                            32'(AXI_BURST_FIXED), 32'(arburst));
                check_value("arsize", 32'(AXI_SIZE_WORD), 32'(arsize));
                check_value("arid", 32'(FETCH_ARID), 32'(arid));
                check_value("araddr", req_cacheable ? {acc_addr[31:4], 4'h0} :
                            {acc_addr[31:2], 2'b00}, araddr);
                ar_owed = 1'b0;
            end
            if (rready && !burst_open) begin
                report_error("rready high with no burst open");
            end
            if (rvalid && rready && rlast) begin
                burst_open = 1'b0;
                if (req_cacheable && !req_flushed) begin   // line lands in the cache
                    line_valid[acc_addr.line.index] = 1'b1;
                    line_tag[acc_addr.line.index]   = acc_addr.line.tag;
                end
            end
            if (req_valid && req_ready) begin
                if (ar_owed) begin
                    report_error("previous miss never issued its AR");
                end
                acc_addr      = req_addr;
                exp_data      = model_data;
                req_cacheable = (req_addr[31:28] == SDRAM_REGION);
                req_hit       = req_cacheable && line_valid[acc_addr.line.index]
                                && (line_tag[acc_addr.line.index] == acc_addr.line.tag);
                ar_owed       = !req_hit;
                burst_open    = !req_hit;
                req_flushed   = 1'b0;
                resp_owed     = 1'b1;
                accept_cycle  = cycles;
                accepted++;
                if (!req_hit) begin
                    ar_expected++;
                end
            end
        end
    end

    initial begin
        seed       = 15132;
        reset      = 1'b1;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        credit     = 1'b0;
        model_addr = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        while (accepted < NUM_REQS || resp_owed || burst_open) begin
            @(posedge clk);
            #2;
            // decoder hands back only credits it was charged for
            credit = (credits < FETCH_CREDITS) && (($random(seed) & 3) == 0);
            flush  = (accepted > 0) && (($random(seed) & 63) == 0);
            if (req_valid && accepted == sent) begin
                req_valid = 1'b0;
            end
            if (!req_valid && sent < NUM_REQS && (($random(seed) & 1) != 0)) begin
                req_addr   = pick_address();
                model_addr = req_addr;
                req_valid  = 1'b1;
                sent++;
            end
        end
        @(posedge clk);
        #2;
        credit = 1'b0;
        flush  = 1'b0;
        repeat (3) @(posedge clk);
        run_done = 1'b1;
    end

endmodule

`default_nettype wire

/* ifetch_top.f */
fetch_pkg.sv
icache_array.sv
axi_refill_master.sv
fetch_return_merge.sv
ifetch_top.sv
tb_axi_mem.sv
tb_ifetch_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ifetch_top
FILELIST = ifetch_top.f
LOG      = sim.log
FAIL_MSG = Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
